// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pad_input_tb \
    -f sim.f \
    -o pad_input_sim \
    && ./obj_dir/pad_input_sim | tee /dev/stderr | grep -q "^TEST OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
verilog/pad_timing_pkg.sv
verilog/pad_frame_pkg.sv
verilog/nes_poll_fsm.sv
verilog/snes_pmod_capture.sv
verilog/snes_frame_filter.sv
verilog/pad_input_top.sv
sim/pad_input_sva.sv
sim/pad_input_tb.sv

// File: sim/pad_input_sva.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_sva (
    input logic                      clk,
    input logic                      reset,
    input logic                      nes_latch,
    input logic                      nes_clk,
    input pad_frame_pkg::nes_state_e state
);

    localparam int PULSE_LEN = int'(pad_timing_pkg::LATCH_CYCLES) + 1;

    logic [15:0] high_len; // clocks since nes_latch went high

    always_ff @(posedge clk) begin
        if (reset) begin
            high_len <= '0;
        end else if (nes_latch) begin
            high_len <= high_len + 16'd1;
        end else begin
            high_len <= '0;
        end
    end

    latch_clk_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(nes_latch && nes_clk))
        else $error("nes_latch and nes_clk high together");

    latch_in_pulse_state: assert property (@(posedge clk) disable iff (reset)
        nes_latch |-> (state == pad_frame_pkg::latch_pulse))
        else $error("nes_latch high outside latch_pulse");

    // pulse length is checked where it ends
    latch_pulse_length: assert property (@(posedge clk) disable iff (reset)
        $fell(nes_latch) |-> (int'(high_len) == PULSE_LEN))
        else $error("nes_latch pulse was %0d clocks long", high_len);

endmodule

bind nes_poll_fsm pad_input_sva u_nes_sva (
    .clk       (clk),
    .reset     (reset),
    .nes_latch (nes_latch),
    .nes_clk   (nes_clk),
    .state     (state)
);

`default_nettype wire

// File: sim/pad_input_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_tb;

    localparam logic [31:0] SEED = 32'hd3055d9f;
    // lengths in clocks, used to size the watchdog
    localparam int NES_FRAME_CLKS  = int'(pad_timing_pkg::LATCH_CYCLES) * 9
                                   + int'(pad_timing_pkg::HALF_CLK_CYCLES) + 2;
    localparam int SNES_FRAME_CLKS = pad_frame_pkg::SNES_BITS * 8 + 4 + 8 + 2;
    localparam int RESET_CLKS      = 4;
    localparam int TIMEOUT_CLKS    = 4 * (RESET_CLKS + 4 * NES_FRAME_CLKS + 3 * SNES_FRAME_CLKS);

    logic clk;
    logic reset;
    logic nes_data;
    logic pmod_data;
    logic pmod_clk;
    logic pmod_latch;
    logic nes_latch;
    logic nes_clk;
    logic a, b, select, start, up, down, left, right;
    logic x, y, l, r;
    logic snes_active;

    logic [7:0]  nes_pattern; // buttons held on the NES pad, A at bit 0
    logic [31:0] lcg_state;
    int          error_count;
    int          tests_run;
    int          tests_failed;

    pad_input_top u_dut (
        .clk (clk), .reset (reset), .nes_data (nes_data),
        .pmod_data (pmod_data), .pmod_clk (pmod_clk), .pmod_latch (pmod_latch),
        .nes_latch (nes_latch), .nes_clk (nes_clk),
        .a (a), .b (b), .select (select), .start (start),
        .up (up), .down (down), .left (left), .right (right),
        .x (x), .y (y), .l (l), .r (r), .snes_active (snes_active)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // NES pad, a shift register loaded by latch and advanced by clk
    initial begin : nes_pad_model
        logic [2:0] idx;
        logic       clk_prev;
        idx      = 3'd0;
        clk_prev = 1'b0;
        nes_data = 1'b1;
        forever begin
            @(posedge clk);
            if (nes_latch) begin
                idx = 3'd0;
                nes_data <= ~nes_pattern[0];
            end else if (nes_clk && !clk_prev && idx < 3'd7) begin
                idx = idx + 3'd1;
                nes_data <= ~nes_pattern[idx]; // active low
            end
            clk_prev = nes_clk;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CLKS) @(posedge clk);
        $display("watchdog expired after %0d clocks, the tests did not finish", TIMEOUT_CLKS);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // outputs in SNES frame order, b at bit 11 down to r at bit 0
    function automatic logic [11:0] output_view();
        return {b, y, select, start, up, down, left, right, a, x, l, r};
    endfunction

    function automatic string output_name(input logic [3:0] idx);
        case (idx)
            4'd0:    return "r";
            4'd1:    return "l";
            4'd2:    return "x";
            4'd3:    return "a";
            4'd4:    return "right";
            4'd5:    return "left";
            4'd6:    return "down";
            4'd7:    return "up";
            4'd8:    return "start";
            4'd9:    return "select";
            4'd10:   return "y";
            default: return "b";
        endcase
    endfunction

    // NES shift order A, B, select, start, up, down, left, right
    function automatic logic [11:0] nes_expected(input logic [7:0] pat);
        return {pat[1], 1'b0, pat[2], pat[3], pat[4], pat[5], pat[6], pat[7],
                pat[0], 3'b000};
    endfunction

    function automatic int count_ones(input logic [11:0] frame);
        int n;
        n = 0;
        for (int i = 0; i < 12; i++) begin
            n = n + int'(frame[i]);
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic expected, input logic actual);
        $display("[FAIL] time %0t: %s expected %0b, got %0b", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic check_outputs(input logic [11:0] expected);
        logic [11:0] actual;
        actual = output_view();
        for (logic [4:0] k = 5'd0; k < 5'd12; k++) begin
            if (actual[k[3:0]] !== expected[k[3:0]]) begin
                report_mismatch(output_name(k[3:0]), expected[k[3:0]], actual[k[3:0]]);
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
        end
        $display("%s finished with %0d errors", name, error_count - errs_before);
    endtask

    // returns one clock after nes_latch has risen
    task automatic wait_latch_rise(output bit ok);
        int cycles;
        cycles = 0;
        while (nes_latch && cycles < NES_FRAME_CLKS) begin
            @(posedge clk);
            cycles++;
        end
        while (!nes_latch && cycles < NES_FRAME_CLKS) begin
            @(posedge clk);
            cycles++;
        end
        ok = (cycles < NES_FRAME_CLKS);
    endtask

    task automatic send_snes_frame(input logic [11:0] frame);
        logic [11:0] bits;
        bits = frame;
        repeat (12) begin
            @(posedge clk);
            pmod_data <= bits[11]; // B goes first
            pmod_clk  <= 1'b0;
            bits = bits << 1;
            repeat (4) @(posedge clk);
            pmod_clk <= 1'b1;
            repeat (3) @(posedge clk);
        end
        @(posedge clk);
        pmod_clk   <= 1'b0;
        pmod_latch <= 1'b1;
        repeat (4) @(posedge clk);
        pmod_latch <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = error_count;
        @(negedge clk);
        check_outputs(12'd0);
        if (snes_active !== 1'b0) report_mismatch("snes_active", 1'b0, snes_active);
        if (nes_clk !== 1'b0) report_mismatch("nes_clk", 1'b0, nes_clk);
        if (nes_latch !== 1'b0) report_mismatch("nes_latch", 1'b0, nes_latch);
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_outputs(12'd0);
            if (snes_active !== 1'b0) report_mismatch("snes_active", 1'b0, snes_active);
            if (nes_clk !== 1'b0) report_mismatch("nes_clk", 1'b0, nes_clk);
        end
        report_test("reset", errs_before);
    endtask

    task automatic test_nes_patterns();
        int          errs_before;
        logic [31:0] rnd;
        logic [7:0]  pat;
        bit          ok;
        errs_before = error_count;
        repeat (2) begin
            rnd = lcg_next();
            pat = rnd[31:24];
            @(posedge clk);
            nes_pattern <= pat;
            wait_latch_rise(ok); // frame that reads the new pattern starts
            if (ok) wait_latch_rise(ok);
            if (!ok) begin
                $display("nes_latch did not rise within %0d clocks", NES_FRAME_CLKS);
                error_count++;
            end else begin
                @(negedge clk);
                check_outputs(nes_expected(pat));
                if (snes_active !== 1'b0) report_mismatch("snes_active", 1'b0, snes_active);
            end
        end
        report_test("nes_patterns", errs_before);
    endtask

    task automatic test_snes_frame();
        int          errs_before;
        logic [31:0] rnd;
        logic [3:0]  i;
        logic [3:0]  j;
        logic [11:0] frame;
        errs_before = error_count;
        rnd = lcg_next();
        i = 4'(rnd[31:16] % 16'd12);
        j = 4'(rnd[15:0] % 16'd12); // may equal i, one button then
        frame = 12'd0;
        frame[i] = 1'b1;
        frame[j] = 1'b1;
        send_snes_frame(frame);
        @(negedge clk);
        if (snes_active !== 1'b1) report_mismatch("snes_active", 1'b1, snes_active);
        check_outputs(frame);
        report_test("snes_frame", errs_before);
    endtask

    task automatic test_snes_crowded();
        int          errs_before;
        logic [31:0] rnd;
        logic [11:0] frame;
        errs_before = error_count;
        frame = 12'd0;
        while (count_ones(frame) < 3 || frame == 12'hfff) begin
            rnd = lcg_next();
            frame = rnd[27:16];
        end
        send_snes_frame(frame);
        @(negedge clk);
        if (snes_active !== 1'b1) report_mismatch("snes_active", 1'b1, snes_active);
        check_outputs(12'd0); // too many presses blank everything
        report_test("snes_crowded", errs_before);
    endtask

    task automatic test_snes_idle();
        int errs_before;
        errs_before = error_count;
        send_snes_frame(12'hfff);
        @(negedge clk);
        if (snes_active !== 1'b0) report_mismatch("snes_active", 1'b0, snes_active);
        check_outputs(nes_expected(nes_pattern));
        report_test("snes_idle", errs_before);
    endtask

    initial begin
        reset        = 1'b1;
        pmod_data    = 1'b0;
        pmod_clk     = 1'b0;
        pmod_latch   = 1'b0;
        nes_pattern  = 8'd0;
        lcg_state    = SEED;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;

        test_reset();
        test_nes_patterns();
        test_snes_frame();
        test_snes_crowded();
        test_snes_idle();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/nes_poll_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module nes_poll_fsm (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 nes_data, // low = pressed
    output logic                                 nes_latch,
    output logic                                 nes_clk,
    output logic [pad_frame_pkg::NES_BITS-1:0]   nes_buttons
);

    // seven clocked slots follow the A bit
    localparam logic [2:0] LAST_SLOT = 3'(pad_frame_pkg::NES_BITS - 2);

    pad_frame_pkg::nes_state_e state;
    pad_frame_pkg::nes_state_e state_next;

    logic [pad_timing_pkg::COUNT_W-1:0] count;
    logic [pad_timing_pkg::COUNT_W-1:0] count_next;
    logic [2:0]                         bit_idx;
    logic [2:0]                         bit_idx_next;

    logic [pad_frame_pkg::NES_BITS-1:0] shift_reg;
    logic                               sample_en;
    logic                               frame_done;

    // end of the last bit slot
    assign frame_done = (state == pad_frame_pkg::read_bit)
                     && (count == pad_timing_pkg::LATCH_CYCLES)
                     && (bit_idx == LAST_SLOT);

    always_comb begin
        state_next   = state;
        count_next   = count + 1'b1;
        bit_idx_next = bit_idx;
        sample_en    = 1'b0;

        case (state)
            pad_frame_pkg::latch_pulse: begin
                if (count == pad_timing_pkg::LATCH_CYCLES) begin
                    state_next = pad_frame_pkg::read_first;
                    count_next = '0;
                end
            end

            pad_frame_pkg::read_first: begin
                sample_en = (count == '0); // A is already on the data pin
                if (count == pad_timing_pkg::HALF_CLK_CYCLES) begin
                    state_next   = pad_frame_pkg::read_bit;
                    count_next   = '0;
                    bit_idx_next = '0;
                end
            end

            pad_frame_pkg::read_bit: begin
                // last clock of the high half
                sample_en = (count == pad_timing_pkg::HALF_CLK_CYCLES);
                if (count == pad_timing_pkg::LATCH_CYCLES) begin
                    count_next = '0;
                    if (bit_idx == LAST_SLOT) begin
                        state_next = pad_frame_pkg::latch_pulse;
                    end else begin
                        bit_idx_next = bit_idx + 3'd1;
                    end
                end
            end

            default: begin
                state_next = pad_frame_pkg::latch_pulse;
                count_next = '0;
            end
        endcase
    end

    // Pins are decoded from the next position, so they line up with the
    // state register. Reset parks the sequencer at the end of a frame and
    // the first edge afterwards starts a latch pulse.
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= pad_frame_pkg::read_bit;
            count     <= pad_timing_pkg::LATCH_CYCLES;
            bit_idx   <= LAST_SLOT;
            nes_latch <= 1'b0;
            nes_clk   <= 1'b0;
        end else begin
            state     <= state_next;
            count     <= count_next;
            bit_idx   <= bit_idx_next;
            nes_latch <= (state_next == pad_frame_pkg::latch_pulse);
            nes_clk   <= (state_next == pad_frame_pkg::read_bit)
                      && (count_next <= pad_timing_pkg::HALF_CLK_CYCLES);
        end
    end

    // button data, shifted in at the top so A ends at bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_reg   <= '0;
            nes_buttons <= '0;
        end else begin
            if (sample_en) begin
                shift_reg <= {~nes_data, shift_reg[pad_frame_pkg::NES_BITS-1:1]};
            end
            if (frame_done) begin
                nes_buttons <= shift_reg; // same edge as the next latch rise
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pad_frame_pkg.sv
`default_nettype none

package pad_frame_pkg;

    localparam int NES_BITS  = 8;
    localparam int SNES_BITS = 12;

    // NES shift order, A comes out first
    localparam int NES_BIT_A      = 0;
    localparam int NES_BIT_B      = 1;
    localparam int NES_BIT_SELECT = 2;
    localparam int NES_BIT_START  = 3;
    localparam int NES_BIT_UP     = 4;
    localparam int NES_BIT_DOWN   = 5;
    localparam int NES_BIT_LEFT   = 6;
    localparam int NES_BIT_RIGHT  = 7;

    // SNES frame, first bit on the wire lands at the top
    localparam int SNES_BIT_B      = 11;
    localparam int SNES_BIT_Y      = 10;
    localparam int SNES_BIT_SELECT = 9;
    localparam int SNES_BIT_START  = 8;
    localparam int SNES_BIT_UP     = 7;
    localparam int SNES_BIT_DOWN   = 6;
    localparam int SNES_BIT_LEFT   = 5;
    localparam int SNES_BIT_RIGHT  = 4;
    localparam int SNES_BIT_A      = 3;
    localparam int SNES_BIT_X      = 2;
    localparam int SNES_BIT_L      = 1;
    localparam int SNES_BIT_R      = 0;

    localparam logic [SNES_BITS-1:0] SNES_IDLE_FRAME = '1; // PMOD with no pad attached
    localparam int MAX_PRESSED = 2;

    typedef enum logic [1:0] {latch_pulse, read_first, read_bit} nes_state_e;

endpackage

`default_nettype wire

// File: verilog/pad_input_top.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_top (
    input  logic clk,
    input  logic reset,
    input  logic nes_data,
    input  logic pmod_data,
    input  logic pmod_clk,
    input  logic pmod_latch,
    output logic nes_latch,
    output logic nes_clk,
    output logic a,
    output logic b,
    output logic select,
    output logic start,
    output logic up,
    output logic down,
    output logic left,
    output logic right,
    output logic x,
    output logic y,
    output logic l,
    output logic r,
    output logic snes_active // 1 = SNES pad in use
);

    logic [pad_frame_pkg::NES_BITS-1:0]  nes_buttons;
    logic [pad_frame_pkg::SNES_BITS-1:0] snes_frame;
    logic [pad_frame_pkg::SNES_BITS-1:0] snes_buttons;
    logic                                snes_present;

    nes_poll_fsm u_nes_poll (
        .clk         (clk),
        .reset       (reset),
        .nes_data    (nes_data),
        .nes_latch   (nes_latch),
        .nes_clk     (nes_clk),
        .nes_buttons (nes_buttons)
    );

    snes_pmod_capture u_snes_capture (
        .clk        (clk),
        .reset      (reset),
        .pmod_data  (pmod_data),
        .pmod_clk   (pmod_clk),
        .pmod_latch (pmod_latch),
        .snes_frame (snes_frame)
    );

    snes_frame_filter u_snes_filter (
        .snes_frame   (snes_frame),
        .snes_buttons (snes_buttons),
        .snes_present (snes_present)
    );

    // SNES wins whenever the PMOD reports a pad
    assign a      = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_A]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_A];
    assign b      = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_B]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_B];
    assign select = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_SELECT]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_SELECT];
    assign start  = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_START]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_START];
    assign up     = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_UP]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_UP];
    assign down   = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_DOWN]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_DOWN];
    assign left   = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_LEFT]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_LEFT];
    assign right  = snes_present ? snes_buttons[pad_frame_pkg::SNES_BIT_RIGHT]
                                 : nes_buttons[pad_frame_pkg::NES_BIT_RIGHT];

    // SNES-only buttons
    assign x = snes_present & snes_buttons[pad_frame_pkg::SNES_BIT_X];
    assign y = snes_present & snes_buttons[pad_frame_pkg::SNES_BIT_Y];
    assign l = snes_present & snes_buttons[pad_frame_pkg::SNES_BIT_L];
    assign r = snes_present & snes_buttons[pad_frame_pkg::SNES_BIT_R];

    assign snes_active = snes_present;

endmodule

`default_nettype wire

// File: verilog/pad_timing_pkg.sv
`default_nettype none

package pad_timing_pkg;

    // NES pin timing, all counts in 64 MHz clocks
    localparam int COUNT_W = 11;

    localparam logic [COUNT_W-1:0] LATCH_CYCLES    = 11'd768; // 12 us
    localparam logic [COUNT_W-1:0] HALF_CLK_CYCLES = 11'd384; // 6 us

    // flops per PMOD pin before any edge detection
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// File: verilog/snes_frame_filter.sv
`timescale 1ns/1ps
`default_nettype none

module snes_frame_filter (
    input  logic [pad_frame_pkg::SNES_BITS-1:0] snes_frame,
    output logic [pad_frame_pkg::SNES_BITS-1:0] snes_buttons,
    output logic                                snes_present
);

    localparam int CNT_W = $clog2(pad_frame_pkg::SNES_BITS + 1);

    logic [CNT_W-1:0] press_count;
    logic             too_many;

    assign snes_present = (snes_frame != pad_frame_pkg::SNES_IDLE_FRAME);

    // number of pressed buttons in the frame
    always_comb begin
        press_count = '0;
        for (int i = 0; i < pad_frame_pkg::SNES_BITS; i++) begin
            press_count = press_count + CNT_W'(snes_frame[i]);
        end
    end

    // the PMOD sometimes delivers a garbled frame with many bits set
    assign too_many = (press_count > CNT_W'(pad_frame_pkg::MAX_PRESSED));

    always_comb begin
        if (!snes_present) begin
            snes_buttons = '0;
        end else if (too_many) begin
            snes_buttons = '0; // pad still counts as present
        end else begin
            snes_buttons = snes_frame;
        end
    end

endmodule

`default_nettype wire

// File: verilog/snes_pmod_capture.sv
`timescale 1ns/1ps
`default_nettype none

module snes_pmod_capture (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 pmod_data,
    input  logic                                 pmod_clk,
    input  logic                                 pmod_latch,
    output logic [pad_frame_pkg::SNES_BITS-1:0]  snes_frame
);

    localparam int STAGES = pad_timing_pkg::SYNC_STAGES;

    // all three pins share one chain: {data, clk, latch}
    logic [STAGES-1:0][2:0] sync_q;
    logic [2:0]             pins_s;
    logic                   clk_prev;
    logic                   latch_prev;
    logic                   clk_rise;
    logic                   latch_rise;

    logic [pad_frame_pkg::SNES_BITS-1:0] shift_reg;

    assign pins_s     = sync_q[STAGES-1];
    assign clk_rise   = pins_s[1] & ~clk_prev;
    assign latch_rise = pins_s[0] & ~latch_prev;

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q     <= '0;
            clk_prev   <= 1'b0;
            latch_prev <= 1'b0;
        end else begin
            sync_q[0] <= {pmod_data, pmod_clk, pmod_latch};
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            clk_prev   <= pins_s[1];
            latch_prev <= pins_s[0];
        end
    end

    // data stays aligned with the clock pin since both pass the same stages
    always_ff @(posedge clk) begin
        if (reset) begin
            shift_reg  <= pad_frame_pkg::SNES_IDLE_FRAME;
            snes_frame <= pad_frame_pkg::SNES_IDLE_FRAME; // reads as no pad
        end else begin
            if (clk_rise) begin
                shift_reg <= {shift_reg[pad_frame_pkg::SNES_BITS-2:0], pins_s[2]};
            end
            if (latch_rise) begin
                snes_frame <= shift_reg;
            end
        end
    end

endmodule

`default_nettype wire
